// File: include/sigmoid_cfg.svh
`ifndef SIGMOID_CFG_SVH
`define SIGMOID_CFG_SVH

////////////////////////////////////////////////////////////
// number formats

// operand and result word width
`define SIG_DATA_W 16

// input is sign-magnitude Q3.12
`define SIG_IN_FRAC 12

// output is unsigned Q0.15
`define SIG_OUT_FRAC 15

////////////////////////////////////////////////////////////
// piecewise fit

// magnitude bits that pick a 0.25 wide segment
`define SIG_SEG_MSB 14
`define SIG_SEG_LSB 10

`define SIG_SEG_NUM 20          // fitted segments, up to 5.0
`define SIG_ONE     16'h8000    // 1.0 in Q0.15

////////////////////////////////////////////////////////////
// control and timing

`define SIG_CNT_W    13         // element counter
`define SIG_PIPE_LAT 4          // sample edge to result edge

`endif

// File: rtl/sigmoid_pkg.sv
`include "sigmoid_cfg.svh"

package sigmoid_pkg;

    // operand or result word
    typedef logic [`SIG_DATA_W-1:0] sig_data_t;

    // element count of one burst
    typedef logic [`SIG_CNT_W-1:0] sig_cnt_t;

    // Q0.15 slope or offset
    typedef logic [`SIG_DATA_W-1:0] sig_coef_t;

    // burst controller states
    typedef enum logic [2:0] {
        st_reset,   // out of reset, waits for idle
        st_wait,    // idle seen, starts on its fall
        st_fetch,   // one sample per cycle
        st_drain,   // pipeline emptying
        st_done     // held until idle
    } sig_state_e;

    // item leaving the segment lookup
    typedef struct packed {
        sig_data_t magnitude;   // folded input, bit 15 clear
        logic      sign;        // reflect at the end
        logic      last;        // final sample of the burst
        sig_coef_t k;
        sig_coef_t b;
    } sig_item_t;

    // record inside the multiply stages
    typedef struct packed {
        logic [2*`SIG_DATA_W-1:0] product;
        sig_coef_t                b;
        logic                     sign;
        logic                     last;
    } sig_mac_t;

endpackage

// File: rtl/sigmoid_stage_if.sv
`timescale 1ns/100ps

// one pipeline item moving between two stages
// no back-pressure, an item advances every cycle
interface sigmoid_stage_if;

    logic                  valid;   // item below is live
    sigmoid_pkg::sig_item_t item;

    ////////////////////////////////////////////////////////////
    // producing stage
    modport src (
        output valid,
        output item
    );

    ////////////////////////////////////////////////////////////
    // consuming stage
    modport dst (
        input valid,
        input item
    );

endinterface

// File: rtl/sigmoid_ctrl.sv
`timescale 1ns/100ps

// burst controller
// starts when idle falls, fetches count samples back to back,
// then waits for the final result and holds done until idle
module sigmoid_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  idle,
    input  sigmoid_pkg::sig_cnt_t count,
    input  logic                  last_out,
    output logic                  fetch,
    output logic                  sample_en,
    output logic                  sample_last,
    output logic                  done
);

    sigmoid_pkg::sig_state_e state;
    sigmoid_pkg::sig_state_e state_nxt;
    sigmoid_pkg::sig_cnt_t   smp_cnt;   // samples taken so far
    sigmoid_pkg::sig_cnt_t   smp_lim;   // index of the final sample
    logic                    cnt_end;

    assign cnt_end = (smp_cnt == smp_lim);

    ////////////////////////////////////////////////////////////
    // state register, idle restarts from anywhere

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= sigmoid_pkg::st_reset;
        end else if (idle) begin
            state <= sigmoid_pkg::st_wait;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            sigmoid_pkg::st_wait: begin
                state_nxt = sigmoid_pkg::st_fetch;
            end
            sigmoid_pkg::st_fetch: begin
                if (cnt_end) begin
                    state_nxt = sigmoid_pkg::st_drain;
                end
            end
            sigmoid_pkg::st_drain: begin
                if (last_out) begin
                    state_nxt = sigmoid_pkg::st_done;
                end
            end
            default: begin
                state_nxt = state;  // reset and done only leave on idle
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // element counter

    always_ff @(posedge clk) begin
        if (!rst || idle) begin
            smp_cnt <= '0;
        end else if (fetch) begin
            smp_cnt <= smp_cnt + 1'b1;
        end
    end

    // limit taken as the burst leaves wait, a count of 0 runs once
    always_ff @(posedge clk) begin
        if (state == sigmoid_pkg::st_wait) begin
            smp_lim <= (count == '0) ? '0 : count - 1'b1;
        end
    end

    assign fetch       = (state == sigmoid_pkg::st_fetch) && !idle;
    assign sample_en   = fetch;
    assign sample_last = fetch && cnt_end;       // marks the final item
    assign done        = (state == sigmoid_pkg::st_done);

endmodule

// File: rtl/sigmoid_segment_lookup.sv
`timescale 1ns/100ps

`include "sigmoid_cfg.svh"

// folds the sign off the input and fetches k and b of its segment
// sample register on sample_en, item register one cycle later
module sigmoid_segment_lookup (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   idle,
    input  logic                   sample_en,
    input  logic                   sample_last,
    input  sigmoid_pkg::sig_data_t data_in,
    sigmoid_stage_if.src           stage
);

    localparam int SEG_W = `SIG_SEG_MSB - `SIG_SEG_LSB + 1;

    // {k, b} per segment, Q0.15
    localparam logic [2*`SIG_DATA_W-1:0] SEG_TAB [`SIG_SEG_NUM] = '{
        {16'h1FD5, 16'h4000},   // 0.24871   0.5
        {16'h1EDD, 16'h403D},   // 0.24113   0.50189
        {16'h1D0A, 16'h4127},   // 0.22688   0.50902
        {16'h1A90, 16'h4303},   // 0.20752   0.52354
        {16'h17AD, 16'h45E6},   // 0.18497   0.54609
        {16'h149F, 16'h49B8},   // 0.1611    0.57593
        {16'h1199, 16'h4E3F},   // 0.13751   0.6113
        {16'h0EC4, 16'h5334},   // 0.11538   0.65004
        {16'h0C36, 16'h5850},   // 0.095414  0.68997
        {16'h09FA, 16'h5D57},   // 0.077965  0.72923
        {16'h0813, 16'h621A},   // 0.063086  0.76643
        {16'h067B, 16'h667B},   // 0.050643  0.80064
        {16'h052B, 16'h6A6A},   // 0.040396  0.83139
        {16'h041A, 16'h6DE2},   // 0.032059  0.85848
        {16'h033E, 16'h70E5},   // 0.025339  0.882
        {16'h028E, 16'h7379},   // 0.019965  0.90216
        {16'h0202, 16'h75A9},   // 0.01569   0.91925
        {16'h0193, 16'h7781},   // 0.012307  0.93363
        {16'h013B, 16'h790A},   // 0.0096378 0.94564
        {16'h00F7, 16'h7A51}    // 0.0075385 0.95561
    };

    logic                   smp_vld;
    logic                   smp_last;
    logic                   smp_sign;
    sigmoid_pkg::sig_data_t smp_mag;
    logic [SEG_W-1:0]       seg_idx;
    sigmoid_pkg::sig_item_t item_nxt;

    ////////////////////////////////////////////////////////////
    // sample and fold

    always_ff @(posedge clk) begin
        if (!rst || idle) begin
            smp_vld <= 1'b0;
        end else begin
            smp_vld <= sample_en;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_en) begin
            smp_mag  <= {1'b0, data_in[`SIG_DATA_W-2:0]};
            smp_sign <= data_in[`SIG_DATA_W-1];
            smp_last <= sample_last;
        end
    end

    ////////////////////////////////////////////////////////////
    // segment table

    assign seg_idx = smp_mag[`SIG_SEG_MSB:`SIG_SEG_LSB];

    always_comb begin
        item_nxt.magnitude = smp_mag;
        item_nxt.sign      = smp_sign;
        item_nxt.last      = smp_last;
        if (seg_idx < `SIG_SEG_NUM) begin
            {item_nxt.k, item_nxt.b} = SEG_TAB[seg_idx];
        end else begin
            item_nxt.k = '0;            // 5.0 and above saturate
            item_nxt.b = `SIG_ONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst || idle) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= smp_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (smp_vld) begin
            stage.item <= item_nxt;
        end
    end

endmodule

// File: rtl/sigmoid_fit_mac.sv
`timescale 1ns/100ps

`include "sigmoid_cfg.svh"

// k*x + b with reflection for negative inputs
// two cycles of multiply, one of add and reflect
module sigmoid_fit_mac (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   idle,
    sigmoid_stage_if.dst           stage,
    output sigmoid_pkg::sig_data_t result,
    output logic                   out_valid,
    output logic                   last_out
);

    localparam int HALF = `SIG_DATA_W / 2;
    localparam int PP_W = `SIG_DATA_W + HALF;

    sigmoid_pkg::sig_mac_t  mul1_q;
    sigmoid_pkg::sig_mac_t  mul2_q;
    logic [PP_W-1:0]        pp_hi_q;     // x times upper byte of k
    logic                   mul1_vld;
    logic                   mul2_vld;
    sigmoid_pkg::sig_data_t fit_sum;
    sigmoid_pkg::sig_data_t fit_res;

    ////////////////////////////////////////////////////////////
    // valid chain, cleared by idle

    always_ff @(posedge clk) begin
        if (!rst || idle) begin
            mul1_vld <= 1'b0;
            mul2_vld <= 1'b0;
        end else begin
            mul1_vld <= stage.valid;
            mul2_vld <= mul1_vld;
        end
    end

    ////////////////////////////////////////////////////////////
    // multiply, partial products then their sum

    always_ff @(posedge clk) begin
        if (stage.valid) begin
            mul1_q.product <= stage.item.magnitude * stage.item.k[HALF-1:0];
            pp_hi_q        <= stage.item.magnitude * stage.item.k[`SIG_DATA_W-1:HALF];
            mul1_q.b       <= stage.item.b;
            mul1_q.sign    <= stage.item.sign;
            mul1_q.last    <= stage.item.last;
        end
    end

    always_ff @(posedge clk) begin
        if (mul1_vld) begin
            mul2_q.product <= mul1_q.product + {pp_hi_q, {HALF{1'b0}}};
            mul2_q.b       <= mul1_q.b;
            mul2_q.sign    <= mul1_q.sign;
            mul2_q.last    <= mul1_q.last;
        end
    end

    ////////////////////////////////////////////////////////////
    // add offset, reflect

    // Q3.27 product down to Q0.15
    assign fit_sum = {mul2_q.product[2*`SIG_DATA_W-1],
                      mul2_q.product[`SIG_IN_FRAC+`SIG_OUT_FRAC-1:`SIG_IN_FRAC]}
                     + mul2_q.b;

    // sigmoid(-x) = 1 - sigmoid(x)
    assign fit_res = mul2_q.sign ? `SIG_ONE - fit_sum : fit_sum;

    always_ff @(posedge clk) begin
        if (!rst || idle) begin
            result    <= '0;
            out_valid <= 1'b0;
            last_out  <= 1'b0;
        end else begin
            out_valid <= mul2_vld;
            last_out  <= mul2_vld && mul2_q.last;
            if (mul2_vld) begin
                result <= fit_res;   // holds between items
            end
        end
    end

endmodule

// File: rtl/sigmoid_unit.sv
`timescale 1ns/100ps

// streaming sigmoid, piecewise linear over 0.25 wide segments
// result of a sample shows four edges after it was taken
module sigmoid_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   idle,
    input  sigmoid_pkg::sig_cnt_t  count,
    input  sigmoid_pkg::sig_data_t data_in,
    output logic                   fetch,
    output sigmoid_pkg::sig_data_t result,
    output logic                   out_valid,
    output logic                   done
);

    logic sample_en;
    logic sample_last;
    logic last_out;     // out_valid of the final result

    sigmoid_stage_if lookup_to_mac ();

    ////////////////////////////////////////////////////////////
    // control

    sigmoid_ctrl i_ctrl (
        .clk         (clk),
        .rst         (rst),
        .idle        (idle),
        .count       (count),
        .last_out    (last_out),
        .fetch       (fetch),
        .sample_en   (sample_en),
        .sample_last (sample_last),
        .done        (done)
    );

    ////////////////////////////////////////////////////////////
    // datapath

    sigmoid_segment_lookup i_lookup (
        .clk         (clk),
        .rst         (rst),
        .idle        (idle),
        .sample_en   (sample_en),
        .sample_last (sample_last),
        .data_in     (data_in),
        .stage       (lookup_to_mac.src)
    );

    sigmoid_fit_mac i_mac (
        .clk         (clk),
        .rst         (rst),
        .idle        (idle),
        .stage       (lookup_to_mac.dst),
        .result      (result),
        .out_valid   (out_valid),
        .last_out    (last_out)
    );

endmodule

// File: test/tb_sigmoid_unit.sv
`timescale 1ns/100ps

`include "sigmoid_cfg.svh"

module tb_sigmoid_unit;

    logic                   clk;
    logic                   rst;
    logic                   idle;
    sigmoid_pkg::sig_cnt_t  count;
    sigmoid_pkg::sig_data_t data_in;
    logic                   fetch;
    sigmoid_pkg::sig_data_t result;
    logic                   out_valid;
    logic                   done;

    int          errs;
    int          tmo_errs;
    logic        stop;          // ends the run early
    int unsigned lcg_state;

    int                     burst_cnt [$];
    int                     burst_cut [$];
    sigmoid_pkg::sig_data_t item_in [$];
    sigmoid_pkg::sig_data_t item_exp [$];

    // samples in flight, oldest first
    sigmoid_pkg::sig_data_t pend_in [$];
    sigmoid_pkg::sig_data_t pend_exp [$];
    int                     pend_cyc [$];
    sigmoid_pkg::sig_data_t twin [sigmoid_pkg::sig_data_t];  // expected positive results

    sigmoid_unit i_dut (
        .clk       (clk),
        .rst       (rst),
        .idle      (idle),
        .count     (count),
        .data_in   (data_in),
        .fetch     (fetch),
        .result    (result),
        .out_valid (out_valid),
        .done      (done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_result(input sigmoid_pkg::sig_data_t got,
                                input sigmoid_pkg::sig_data_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            errs++;
        end
    endtask

    task automatic check_count(input sigmoid_pkg::sig_cnt_t got,
                               input sigmoid_pkg::sig_cnt_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errs++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            errs++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        tmo_errs++;
        stop = 1'b1;
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    ////////////////////////////////////////////////////////////
    // stim file, one tag character per line

    task automatic load_stim();
        int                     fd;
        int                     c;
        int                     n;
        int                     cnt;
        int                     cut;
        sigmoid_pkg::sig_data_t din;
        sigmoid_pkg::sig_data_t exp;
        fd = $fopen("test/sigmoid_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open test/sigmoid_stim.txt");
            stop = 1'b1;
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                while (c != -1 && c != "\n") c = $fgetc(fd);   // comment line
            end else if (c == "b") begin
                n = $fscanf(fd, "%d %d", cnt, cut);
                if (n != 2) begin
                    $display("bad burst header in test/sigmoid_stim.txt");
                    stop = 1'b1;
                end
                burst_cnt.push_back(cnt);
                burst_cut.push_back(cut);
            end else if (c == "d") begin
                n = $fscanf(fd, "%h %h", din, exp);
                if (n != 2) begin
                    $display("bad item line in test/sigmoid_stim.txt");
                    stop = 1'b1;
                end
                item_in.push_back(din);
                item_exp.push_back(exp);
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // one burst: idle gap, samples while fetch, results, done

    task automatic run_burst(input int cnt, input int cut, input int base);
        int                     n_exp;
        int                     gap;
        int                     taken;
        int                     outs;
        int                     cyc;
        sigmoid_pkg::sig_data_t din;
        sigmoid_pkg::sig_data_t exp;
        sigmoid_pkg::sig_data_t mag;
        n_exp = (cnt == 0) ? 1 : cnt;   // count 0 runs once
        gap   = 2 + int'(lcg_next() % 4);
        taken = 0;
        outs  = 0;
        cyc   = 0;
        pend_in.delete();
        pend_exp.delete();
        pend_cyc.delete();
        twin.delete();
        idle  = 1'b1;                   // also cuts a burst left running
        count = sigmoid_pkg::sig_cnt_t'(cnt);
        for (int i = 0; i < gap; i++) begin
            @(negedge clk);
            check_flag(fetch, 1'b0, "fetch while idle");
            check_flag(out_valid, 1'b0, "out_valid while idle");
            check_flag(done, 1'b0, "done while idle");
        end
        idle = 1'b0;
        while (outs < n_exp) begin
            @(negedge clk);
            cyc++;
            if (out_valid) begin
                if (pend_exp.size() == 0) begin
                    $display("out_valid at %0t with no sample in flight", $time);
                    errs++;
                end else begin
                    din = pend_in.pop_front();
                    exp = pend_exp.pop_front();
                    mag = {1'b0, din[`SIG_DATA_W-2:0]};
                    check_result(result, exp, $sformatf("result for %h", din));
                    // sample edge is half a cycle after the negedge that drove it
                    check_count(sigmoid_pkg::sig_cnt_t'(cyc - pend_cyc.pop_front()),
                                sigmoid_pkg::sig_cnt_t'(`SIG_PIPE_LAT + 1), "result latency");
                    if (!din[`SIG_DATA_W-1]) begin
                        twin[mag] = exp;
                    end else if (twin.exists(mag)) begin
                        check_result(result, `SIG_ONE - twin[mag],
                                     $sformatf("reflection of %h", din));
                    end
                end
                outs++;
            end
            check_flag(done, 1'b0, "done before the last result");
            if (cut != 0 && taken == cut) begin
                return;                 // restart mid burst
            end
            if (fetch) begin
                if (taken < n_exp) begin
                    data_in = item_in[base + taken];
                    pend_in.push_back(item_in[base + taken]);
                    pend_exp.push_back(item_exp[base + taken]);
                    pend_cyc.push_back(cyc);
                end
                taken++;
            end
            if (cyc > n_exp + 4 * `SIG_PIPE_LAT) begin
                report_timeout("the results of a burst");
                return;
            end
        end
        check_count(sigmoid_pkg::sig_cnt_t'(taken), sigmoid_pkg::sig_cnt_t'(n_exp),
                    "fetch cycles");
        cyc = 0;
        while (!done) begin
            @(negedge clk);
            cyc++;
            check_flag(out_valid, 1'b0, "out_valid after the last result");
            check_flag(fetch, 1'b0, "fetch after the last sample");
            if (cyc > 2 * `SIG_PIPE_LAT) begin
                report_timeout("done");
                return;
            end
        end
        check_count(sigmoid_pkg::sig_cnt_t'(cyc), 1, "cycles from last result to done");
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            check_flag(done, 1'b1, "done held until idle");
            check_flag(out_valid, 1'b0, "out_valid after done");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int base;
        rst       = 1'b0;
        idle      = 1'b1;
        count     = '0;
        data_in   = '0;
        errs      = 0;
        tmo_errs  = 0;
        stop      = 1'b0;
        lcg_state = 59;
        base      = 0;
        load_stim();
        for (int i = 0; i < 4; i++) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_flag(fetch, 1'b0, "fetch after reset");
        check_flag(out_valid, 1'b0, "out_valid after reset");
        check_flag(done, 1'b0, "done after reset");
        check_result(result, '0, "result after reset");
        for (int b = 0; b < burst_cnt.size() && !stop; b++) begin
            run_burst(burst_cnt[b], burst_cut[b], base);
            base += (burst_cnt[b] == 0) ? 1 : burst_cnt[b];
        end
        idle = 1'b1;
        @(negedge clk);
        $display("bursts run: %0d, value errors: %0d, timeouts: %0d",
                 burst_cnt.size(), errs, tmo_errs);
        if (errs == 0 && tmo_errs == 0 && !stop) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sigmoid_unit.f
+incdir+include
rtl/sigmoid_pkg.sv
rtl/sigmoid_stage_if.sv
rtl/sigmoid_ctrl.sv
rtl/sigmoid_segment_lookup.sv
rtl/sigmoid_fit_mac.sv
rtl/sigmoid_unit.sv
test/tb_sigmoid_unit.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for a failure

cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f sigmoid_unit.f \
        --top-module tb_sigmoid_unit -Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "TESTBENCH FAILED" sim.log \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed, see build.log and sim.log"; exit 1; }

// File: test/sigmoid_stim.txt
# b <count> <cut>  burst header, cut = samples taken before idle restarts it, 0 = full burst
# d <input> <expected>  sign-magnitude Q3.12 in, Q0.15 out, both hex
b 6 0
d 0000 4000
d 0200 43fa
d 0400 47f4
d 0800 4fac
d 13ff 637c
d 1400 637e
b 6 0
d 3000 79eb
d b000 0615
d 2800 7649
d a800 09b7
d 1000 5d93
d 9000 226d
b 4 3
d 2000 70bc
d a000 0f44
d 8800 3054
d 8400 380c
b 6 0
d 4fff 7f23
d cfff 00dd
d 5000 8000
d d000 0000
d 7fff 8000
d ffff 0000
b 0 0
d 8000 4000
